// File: csr_decode.sv
// ==========================================================
// CSR address decode and access check
// Builds the one-hot select and decides legality of a write
// Purely combinational, sits in front of the register state
// ==========================================================

`timescale 1ns/1ps

module csr_decode (
  input  rv_csr_pkg::csr_addr_t addr,
  input  logic                  we,
  input  rv_csr_pkg::priv_e     current_priv,
  output rv_csr_pkg::csr_sel_t  sel,
  output logic                  wr_en,
  output logic                  illegal_csr
);

  import rv_csr_pkg::*;

  logic [1:0] addr_priv;    // Lowest privilege allowed by the address
  logic       addr_exists;
  logic       addr_ro;
  logic       priv_ok;
  logic       illegal;

  // ========================================================
  // One-hot select
  // ========================================================
  always_comb begin
    sel           = '0;
    sel.mstatus   = (addr == CSR_MSTATUS);
    sel.misa      = (addr == CSR_MISA);
    sel.mtvec     = (addr == CSR_MTVEC);
    sel.mscratch  = (addr == CSR_MSCRATCH);
    sel.mepc      = (addr == CSR_MEPC);
    sel.mcause    = (addr == CSR_MCAUSE);
    sel.mtval     = (addr == CSR_MTVAL);
    sel.mvendorid = (addr == CSR_MVENDORID);
    sel.marchid   = (addr == CSR_MARCHID);
    sel.mimpid    = (addr == CSR_MIMPID);
    sel.mhartid   = (addr == CSR_MHARTID);
  end

  // Any bit set means a kept register
  assign addr_exists = |sel;

  // ========================================================
  // Access rights from the address encoding
  // ========================================================
  // addr[9:8] is the minimum privilege level
  assign addr_priv = addr[9:8];

  // Current level must reach the level in the address
  assign priv_ok = (current_priv >= addr_priv);

  // addr[11:10] == 11 marks read-only space, misa is read-only here too
  assign addr_ro = (addr[11:10] == 2'b11) || sel.misa;

  // Single place where legality is decided
  assign illegal = !addr_exists || !priv_ok || addr_ro;

  // Flag only matters for an actual access
  assign illegal_csr = we && illegal;

  // Commit only legal writes
  assign wr_en = we && !illegal;

endmodule

// File: csr_file_top.sv
// ==========================================================
// Machine-mode CSR block, top level
// Decode, register state and read mux, plus the status
// signals the pipeline uses for traps and MRET
// ==========================================================

`timescale 1ns/1ps

`include "rv_csr_config.svh"

module csr_file_top (
  input  logic                  clk,
  input  logic                  reset_n,
  input  rv_csr_pkg::csr_req_t  req,
  input  rv_csr_pkg::trap_req_t trap,
  input  logic                  mret,
  input  rv_csr_pkg::priv_e     current_priv,
  output logic [`XLEN-1:0]      rdata,         // Same cycle as req
  output logic                  illegal_csr,   // Same cycle as req
  output logic [`XLEN-1:0]      trap_vector,   // Handler address
  output logic [`XLEN-1:0]      mepc_out,      // MRET target
  output logic                  mstatus_mie,   // Global interrupt enable
  output rv_csr_pkg::priv_e     mpp_out
);

  import rv_csr_pkg::*;

  csr_sel_t   sel;
  csr_state_t state;
  logic       wr_en;   // Legal write this cycle

  csr_decode u_decode (
    .addr         (req.addr),
    .we           (req.we),
    .current_priv (current_priv),
    .sel          (sel),
    .wr_en        (wr_en),
    .illegal_csr  (illegal_csr)
  );

  csr_machine_state u_state (
    .clk          (clk),
    .reset_n      (reset_n),
    .sel          (sel),
    .wr_en        (wr_en),
    .op           (req.op),
    .wdata        (req.wdata),
    .rdata        (rdata),          // Old value feeds set and clear
    .trap         (trap),
    .mret         (mret),
    .current_priv (current_priv),
    .state        (state)
  );

  csr_read_mux u_read_mux (
    .sel   (sel),
    .state (state),
    .rdata (rdata)
  );

  // Status straight from the registers
  assign trap_vector = state.mtvec;
  assign mepc_out    = state.mepc;
  assign mstatus_mie = state.mstatus.mie;
  assign mpp_out     = state.mstatus.mpp;

endmodule

// File: csr_machine_state.sv
// ==========================================================
// Machine-mode CSR storage
// Computes the CSR write value and updates the registers
// Priority per cycle is trap entry, then MRET, then a write
// ==========================================================

`timescale 1ns/1ps

`include "rv_csr_config.svh"

module csr_machine_state (
  input  logic                   clk,
  input  logic                   reset_n,
  input  rv_csr_pkg::csr_sel_t   sel,
  input  logic                   wr_en,
  input  rv_csr_pkg::csr_op_e    op,
  input  logic [`XLEN-1:0]       wdata,
  input  logic [`XLEN-1:0]       rdata,
  input  rv_csr_pkg::trap_req_t  trap,
  input  logic                   mret,
  input  rv_csr_pkg::priv_e      current_priv,
  output rv_csr_pkg::csr_state_t state
);

  import rv_csr_pkg::*;

  logic [`XLEN-1:0] wval;          // Value after RW/RS/RC
  logic [`XLEN-1:0] wval_aligned;  // Low two bits forced to zero
  logic [`XLEN-1:0] cause_ext;

  // ========================================================
  // Write value
  // ========================================================
  // Set and clear work on the current read value
  always_comb begin
    case (op)
      CSR_OP_RW,
      CSR_OP_RWI: wval = wdata;
      CSR_OP_RS,
      CSR_OP_RSI: wval = rdata | wdata;    // Set bits
      CSR_OP_RC,
      CSR_OP_RCI: wval = rdata & ~wdata;   // Clear bits
      default:    wval = rdata;            // No change
    endcase
  end

  // mtvec and mepc hold word addresses only
  assign wval_aligned = {wval[`XLEN-1:2], 2'b00};

  // Cause code widened to a full register
  assign cause_ext = {{(`XLEN-5){1'b0}}, trap.cause};

  // ========================================================
  // Register update
  // ========================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state.mstatus.mie  <= 1'b0;              // Interrupts off
      state.mstatus.mpie <= 1'b0;
      state.mstatus.mpp  <= priv_e'(`CSR_MPP_RESET);
      state.mtvec        <= `CSR_REG_RESET;
      state.mscratch     <= `CSR_REG_RESET;
      state.mepc         <= `CSR_REG_RESET;
      state.mcause       <= `CSR_REG_RESET;
      state.mtval        <= `CSR_REG_RESET;
    end else if (trap.entry) begin
      // Every trap lands in machine mode
      state.mepc         <= trap.pc;
      state.mcause       <= cause_ext;
      state.mtval        <= trap.val;
      state.mstatus.mpie <= state.mstatus.mie;  // Stack the enable
      state.mstatus.mie  <= 1'b0;
      state.mstatus.mpp  <= current_priv;       // Stack the privilege
    end else if (mret) begin
      // Pop the stack
      state.mstatus.mie  <= state.mstatus.mpie;
      state.mstatus.mpie <= 1'b1;
      state.mstatus.mpp  <= PRIV_M;
    end else if (wr_en) begin
      // Decode has already rejected read-only and unknown addresses
      case (1'b1)
        sel.mstatus: begin
          // Only MIE, MPIE and MPP are kept, other bits dropped
          state.mstatus.mie  <= wval[3];
          state.mstatus.mpie <= wval[7];
          state.mstatus.mpp  <= priv_e'(wval[12:11]);
        end
        sel.mtvec:    state.mtvec    <= wval_aligned;
        sel.mscratch: state.mscratch <= wval;
        sel.mepc:     state.mepc     <= wval_aligned;
        sel.mcause:   state.mcause   <= wval;
        sel.mtval:    state.mtval    <= wval;
        default: begin
          // Identity registers and misa never change
        end
      endcase
    end
  end

endmodule

// File: csr_read_mux.sv
// ==========================================================
// CSR read data selection
// AND-OR mux over the one-hot select, zero for unknown
// addresses, combinational in the access cycle
// ==========================================================

`timescale 1ns/1ps

`include "rv_csr_config.svh"

module csr_read_mux (
  input  rv_csr_pkg::csr_sel_t   sel,
  input  rv_csr_pkg::csr_state_t state,
  output logic [`XLEN-1:0]       rdata
);

  import rv_csr_pkg::*;

  logic [`XLEN-1:0] mstatus_word;

  // ========================================================
  // Architectural mstatus layout
  // ========================================================
  assign mstatus_word = {
    {(`XLEN-13){1'b0}},   // [31:13] Not kept
    state.mstatus.mpp,    // [12:11] MPP
    3'b000,               // [10:8]
    state.mstatus.mpie,   // [7] MPIE
    3'b000,               // [6:4]
    state.mstatus.mie,    // [3] MIE
    3'b000                // [2:0]
  };

  // ========================================================
  // Select
  // ========================================================
  // At most one term is live, none gives zero
  always_comb begin
    rdata = '0;
    rdata |= {`XLEN{sel.mstatus}}   & mstatus_word;
    rdata |= {`XLEN{sel.misa}}      & `XLEN'(`CSR_MISA_VAL);
    rdata |= {`XLEN{sel.mtvec}}     & state.mtvec;
    rdata |= {`XLEN{sel.mscratch}}  & state.mscratch;
    rdata |= {`XLEN{sel.mepc}}      & state.mepc;
    rdata |= {`XLEN{sel.mcause}}    & state.mcause;
    rdata |= {`XLEN{sel.mtval}}     & state.mtval;
    // Identity values, zero-extended
    rdata |= {`XLEN{sel.mvendorid}} & `XLEN'(`CSR_MVENDORID_VAL);
    rdata |= {`XLEN{sel.marchid}}   & `XLEN'(`CSR_MARCHID_VAL);
    rdata |= {`XLEN{sel.mimpid}}    & `XLEN'(`CSR_MIMPID_VAL);
    rdata |= {`XLEN{sel.mhartid}}   & `XLEN'(`CSR_MHARTID_VAL);
  end

endmodule

// File: rv_csr_config.svh
// ==========================================================
// Build constants for the machine-mode CSR block
// Data width, identity register values and reset values
// Include wherever `XLEN or an identity value is needed
// ==========================================================

`ifndef RV_CSR_CONFIG_SVH
`define RV_CSR_CONFIG_SVH

// Data path width, RV32 only
`define XLEN 32

// Identity registers, all read-only
`define CSR_MVENDORID_VAL 32'h0000_0000  // Non-commercial
`define CSR_MARCHID_VAL   32'h0000_0000  // Not assigned
`define CSR_MIMPID_VAL    32'h0000_0001  // First implementation
`define CSR_MHARTID_VAL   32'h0000_0000  // Single hart

// MXL = 1 (RV32), extension bit 8 = I
`define CSR_MISA_VAL      {2'b01, 4'b0000, 26'h000_0100}

// Reset values
`define CSR_MPP_RESET     2'b11          // Previous privilege starts as M
`define CSR_REG_RESET     32'h0000_0000  // mtvec, mscratch, mepc, mcause, mtval

`endif

// File: rv_csr_pkg.sv
// ==========================================================
// Shared types for the machine-mode CSR block
// Addresses, operation and privilege encodings, and the
// packed structs passed between decode, state and read mux
// ==========================================================

`include "rv_csr_config.svh"

package rv_csr_pkg;

  // ========================================================
  // Encodings
  // ========================================================
  typedef logic [11:0] csr_addr_t;

  // funct3 of the CSR instructions, other codes leave the register as is
  typedef enum logic [2:0] {
    CSR_OP_RW  = 3'b001,
    CSR_OP_RS  = 3'b010,
    CSR_OP_RC  = 3'b011,
    CSR_OP_RWI = 3'b101,
    CSR_OP_RSI = 3'b110,
    CSR_OP_RCI = 3'b111
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  // Kept addresses
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MISA      = 12'h301;  // Read-only by rule, not by encoding
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MTVAL     = 12'h343;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  // ========================================================
  // Structs
  // ========================================================
  typedef struct packed {
    csr_addr_t          addr;
    logic [`XLEN-1:0]   wdata;   // rs1 value or zero-extended uimm
    csr_op_e            op;
    logic               we;      // Access present and may write
  } csr_req_t;

  typedef struct packed {
    logic               entry;   // Trap taken this cycle
    logic [`XLEN-1:0]   pc;
    logic [4:0]         cause;
    logic [`XLEN-1:0]   val;
  } trap_req_t;

  // One bit per kept address, at most one set
  typedef struct packed {
    logic mstatus;
    logic misa;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mtval;
    logic mvendorid;
    logic marchid;
    logic mimpid;
    logic mhartid;
  } csr_sel_t;

  typedef struct packed {
    logic  mie;
    logic  mpie;
    priv_e mpp;
  } mstatus_t;

  typedef struct packed {
    mstatus_t           mstatus;
    logic [`XLEN-1:0]   mtvec;
    logic [`XLEN-1:0]   mscratch;
    logic [`XLEN-1:0]   mepc;
    logic [`XLEN-1:0]   mcause;
    logic [`XLEN-1:0]   mtval;
  } csr_state_t;

endpackage

// File: sources.f
+incdir+.
rv_csr_pkg.sv
csr_decode.sv
csr_read_mux.sv
csr_machine_state.sv
csr_file_top.sv
tb_csr_file.sv

// File: tb_csr_file.sv
// ==========================================================
// Testbench for the machine-mode CSR block
// LFSR stimulus checked against a register model, with one
// line per test and a summary line at the end
// ==========================================================

`timescale 1ns/1ps

`include "rv_csr_config.svh"

module tb_csr_file;

  import rv_csr_pkg::*;

  // Iterations per test
  localparam int N_RW    = 200;
  localparam int N_ILL   = 100;
  localparam int N_TRAP  = 40;
  localparam int N_MRET  = 40;
  localparam int N_COMBO = 40;
  // Reset, reads and every test loop plus a little slack
  localparam int TOTAL_CYCLES = 10 + 12 + N_RW * 2 + N_ILL + 12 + N_TRAP * 5
                              + N_MRET * 4 + N_COMBO * 2 + 10;

  logic             clk;
  logic             reset_n;
  csr_req_t         req;
  trap_req_t        trap;
  logic             mret;
  priv_e            current_priv;
  logic [`XLEN-1:0] rdata;
  logic             illegal_csr;
  logic [`XLEN-1:0] trap_vector;
  logic [`XLEN-1:0] mepc_out;
  logic             mstatus_mie;
  priv_e            mpp_out;

  // Register model
  logic        m_mie;
  logic        m_mpie;
  logic [1:0]  m_mpp;
  logic [31:0] m_mtvec;
  logic [31:0] m_mscratch;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_mtval;

  logic [31:0] lfsr;           // Stimulus generator state
  int          checks;
  int          errors;
  int          mark_checks;    // Counts at the start of the current test
  int          mark_errors;

  csr_addr_t kept_addrs[11] = '{CSR_MSTATUS, CSR_MISA, CSR_MTVEC, CSR_MSCRATCH,
                                CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MVENDORID,
                                CSR_MARCHID, CSR_MIMPID, CSR_MHARTID};
  csr_addr_t rw_addrs[6]    = '{CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH,
                                CSR_MEPC, CSR_MCAUSE, CSR_MTVAL};
  csr_addr_t ro_addrs[5]    = '{CSR_MISA, CSR_MVENDORID, CSR_MARCHID,
                                CSR_MIMPID, CSR_MHARTID};
  csr_op_e   ops[6]         = '{CSR_OP_RW, CSR_OP_RS, CSR_OP_RC,
                                CSR_OP_RWI, CSR_OP_RSI, CSR_OP_RCI};

  csr_file_top dut0 (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (req),
    .trap         (trap),
    .mret         (mret),
    .current_priv (current_priv),
    .rdata        (rdata),
    .illegal_csr  (illegal_csr),
    .trap_vector  (trap_vector),
    .mepc_out     (mepc_out),
    .mstatus_mie  (mstatus_mie),
    .mpp_out      (mpp_out)
  );

  always #4 clk = ~clk;  // 8 ns period

  // ========================================================
  // Random numbers and model rules
  // ========================================================
  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      if (lfsr[0]) lfsr = (lfsr >> 1) ^ 32'h8020_0003;
      else         lfsr = lfsr >> 1;
    end
    return v;
  endfunction

  function automatic logic is_kept(input csr_addr_t addr);
    int i;
    is_kept = 1'b0;
    for (i = 0; i < 11; i++) if (kept_addrs[i] == addr) is_kept = 1'b1;
  endfunction

  // Known address, enough privilege, not read-only
  function automatic logic access_legal(input csr_addr_t addr, input priv_e priv);
    logic [1:0] p;
    p = priv;
    return is_kept(addr) && (p >= addr[9:8]) && (addr[11:10] != 2'b11)
           && (addr != CSR_MISA);
  endfunction

  function automatic logic [31:0] expected_read(input csr_addr_t addr);
    case (addr)
      CSR_MSTATUS:   return {19'b0, m_mpp, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
      CSR_MISA:      return `CSR_MISA_VAL;
      CSR_MTVEC:     return m_mtvec;
      CSR_MSCRATCH:  return m_mscratch;
      CSR_MEPC:      return m_mepc;
      CSR_MCAUSE:    return m_mcause;
      CSR_MTVAL:     return m_mtval;
      CSR_MVENDORID: return `CSR_MVENDORID_VAL;
      CSR_MARCHID:   return `CSR_MARCHID_VAL;
      CSR_MIMPID:    return `CSR_MIMPID_VAL;
      CSR_MHARTID:   return `CSR_MHARTID_VAL;
      default:       return 32'h0;  // Unknown reads zero
    endcase
  endfunction

  function automatic logic [31:0] write_value(input csr_op_e op, input logic [31:0] old,
                                              input logic [31:0] wd);
    case (op)
      CSR_OP_RW, CSR_OP_RWI: return wd;
      CSR_OP_RS, CSR_OP_RSI: return old | wd;
      CSR_OP_RC, CSR_OP_RCI: return old & ~wd;
      default:               return old;
    endcase
  endfunction

  task automatic apply_write(input csr_addr_t addr, input logic [31:0] v);
    case (addr)
      CSR_MSTATUS: begin
        m_mie  = v[3];
        m_mpie = v[7];
        m_mpp  = v[12:11];
      end
      CSR_MTVEC:    m_mtvec    = v & ~32'h3;  // Word aligned
      CSR_MSCRATCH: m_mscratch = v;
      CSR_MEPC:     m_mepc     = v & ~32'h3;
      CSR_MCAUSE:   m_mcause   = v;
      CSR_MTVAL:    m_mtval    = v;
      default: ;
    endcase
  endtask

  // ========================================================
  // Checks and cycle driver
  // ========================================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %08h expected %08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic finish_test(input string name);
    $display("Test %-10s %0d checks, %0d errors", name, checks - mark_checks,
             errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  // Drive one cycle, check at the falling edge, then step the model
  task automatic run_cycle(input csr_req_t r, input trap_req_t t, input logic m,
                           input priv_e p);
    logic legal;
    @(posedge clk);
    req          <= r;
    trap         <= t;
    mret         <= m;
    current_priv <= p;
    @(negedge clk);
    legal = access_legal(r.addr, p);
    check_value("illegal_csr", illegal_csr, r.we && !legal);
    check_value("rdata", rdata, expected_read(r.addr));
    check_value("trap_vector", trap_vector, m_mtvec);
    check_value("mepc_out", mepc_out, m_mepc);
    check_value("mstatus_mie", mstatus_mie, m_mie);
    check_value("mpp_out", mpp_out, m_mpp);
    if (t.entry) begin
      m_mepc   = t.pc;
      m_mcause = {27'b0, t.cause};
      m_mtval  = t.val;
      m_mpie   = m_mie;  // Stack enable and privilege
      m_mie    = 1'b0;
      m_mpp    = p;
    end else if (m) begin
      m_mie  = m_mpie;
      m_mpie = 1'b1;
      m_mpp  = 2'b11;
    end else if (r.we && legal) begin
      apply_write(r.addr, write_value(r.op, expected_read(r.addr), r.wdata));
    end
  endtask

  task automatic csr_access(input csr_addr_t addr, input csr_op_e op,
                            input logic [31:0] wdata, input logic we, input priv_e p);
    csr_req_t r;
    r.addr  = addr;
    r.wdata = wdata;
    r.op    = op;
    r.we    = we;
    run_cycle(r, '0, 1'b0, p);
  endtask

  // Random trap with optional MRET and request in the same cycle
  task automatic take_trap(input csr_req_t r, input logic with_mret);
    trap_req_t  t;
    logic [1:0] p;
    t.entry = 1'b1;
    t.pc    = lfsr_bits(32);
    t.cause = lfsr_bits(5);
    t.val   = lfsr_bits(32);
    p       = lfsr_bits(2);
    if (p == 2'b10) p = 2'b11;  // No such level
    if (r.we) p = 2'b11;        // Same-cycle write needs machine level
    run_cycle(r, t, with_mret, priv_e'(p));
  endtask

  function automatic csr_op_e random_op();
    return ops[lfsr_bits(3) % 6];
  endfunction

  // Immediate forms carry a 5-bit uimm
  function automatic logic [31:0] random_wdata(input csr_op_e op);
    logic [2:0] code;
    logic [4:0] uimm;
    code = op;
    if (code[2]) begin
      uimm = lfsr_bits(5);
      return {27'b0, uimm};
    end
    return lfsr_bits(32);
  endfunction

  // ========================================================
  // Watchdog
  // ========================================================
  initial begin
    #(2 * TOTAL_CYCLES * 8);
    $display("Timeout: the run did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display("Test failures found");
    $finish;
  end

  // ========================================================
  // Test sequence
  // ========================================================
  initial begin
    csr_req_t  r;
    csr_addr_t a;
    csr_op_e   op;
    int        i;
    int        kind;
    clk          = 1'b0;
    reset_n      = 1'b0;
    req          = '0;
    trap         = '0;
    mret         = 1'b0;
    current_priv = PRIV_M;
    lfsr         = 32'd19;
    checks       = 0;
    errors       = 0;
    mark_checks  = 0;
    mark_errors  = 0;
    m_mie        = 1'b0;
    m_mpie       = 1'b0;
    m_mpp        = `CSR_MPP_RESET;
    m_mtvec      = '0;
    m_mscratch   = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    m_mtval      = '0;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;

    // Reset values by plain reads
    for (i = 0; i < 11; i++) csr_access(kept_addrs[i], CSR_OP_RW, '0, 1'b0, PRIV_M);
    check_value("mpp_out", mpp_out, 32'(PRIV_M));
    finish_test("reset");

    // Legal writes at machine level with a read back one cycle later
    for (i = 0; i < N_RW; i++) begin
      a  = rw_addrs[lfsr_bits(3) % 6];
      op = random_op();
      csr_access(a, op, random_wdata(op), 1'b1, PRIV_M);
      csr_access(a, CSR_OP_RW, '0, 1'b0, PRIV_M);
    end
    finish_test("rw");

    // Read-only, unknown and under-privileged writes
    for (i = 0; i < N_ILL; i++) begin
      kind = lfsr_bits(2) % 3;
      op   = random_op();
      if (kind == 0) begin
        csr_access(ro_addrs[lfsr_bits(3) % 5], op, random_wdata(op), 1'b1, PRIV_M);
      end else if (kind == 1) begin
        do a = lfsr_bits(12); while (is_kept(a));
        csr_access(a, op, random_wdata(op), lfsr_bits(1), PRIV_M);
      end else begin
        csr_access(rw_addrs[lfsr_bits(3) % 6], op, random_wdata(op), 1'b1, PRIV_U);
      end
    end
    // State must be untouched
    for (i = 0; i < 11; i++) csr_access(kept_addrs[i], CSR_OP_RW, '0, 1'b0, PRIV_M);
    finish_test("illegal");

    // Trap entry
    for (i = 0; i < N_TRAP; i++) begin
      csr_access(CSR_MSTATUS, CSR_OP_RW, lfsr_bits(32), 1'b1, PRIV_M);
      take_trap('0, 1'b0);
      csr_access(CSR_MCAUSE, CSR_OP_RW, '0, 1'b0, PRIV_M);
      csr_access(CSR_MTVAL, CSR_OP_RW, '0, 1'b0, PRIV_M);
      csr_access(CSR_MSTATUS, CSR_OP_RW, '0, 1'b0, PRIV_M);  // MPIE and MPP
    end
    finish_test("trap");

    // MRET after a trap
    for (i = 0; i < N_MRET; i++) begin
      csr_access(CSR_MSTATUS, CSR_OP_RW, lfsr_bits(32), 1'b1, PRIV_M);
      take_trap('0, 1'b0);
      run_cycle('0, '0, 1'b1, PRIV_M);
      csr_access(CSR_MSTATUS, CSR_OP_RW, '0, 1'b0, PRIV_M);
    end
    finish_test("mret");

    // Trap wins over MRET and a legal write in the same cycle
    for (i = 0; i < N_COMBO; i++) begin
      r.addr  = rw_addrs[lfsr_bits(3) % 6];
      r.op    = random_op();
      r.wdata = random_wdata(r.op);
      r.we    = 1'b1;
      take_trap(r, 1'b1);
      csr_access(r.addr, CSR_OP_RW, '0, 1'b0, PRIV_M);
    end
    finish_test("priority");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
